//--- flist.f
rv_isa_pkg.sv
rv_bus_pkg.sv
instr_decoder.sv
alu.sv
regfile.sv
core_ctrl.sv
rv_core_top.sv
tb_clkgen.sv
tb_wb_mem.sv
tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build tb_rv_core with Verilator, run it, judge the result from sim.log
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary --assert --top-module tb_rv_core -f flist.f \
        -o tb_rv_core_sim > build.log 2>&1 \
    && ./obj_dir/tb_rv_core_sim > sim.log 2>&1 \
    && grep -qx "Done: no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
exit 0

//--- tb_rv_core.sv
// ==================================================
// Testbench for rv_core_top
// Test program, expected store table, SVA checks
// ==================================================
`timescale 1ns/10ps

module tb_rv_core;
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    localparam int opc_imm   = 'h13;
    localparam int opc_load  = 'h03;
    localparam int opc_lui   = 'h37;
    localparam int opc_auipc = 'h17;
    localparam int opc_jalr  = 'h67;
    localparam int halt_timeout = 5000;   // Cycles

    logic      clk, rst_n, halted;
    ibus_req_t iwb_req;
    dbus_req_t dwb_req;
    bus_rsp_t  iwb_rsp, dwb_rsp;
    word_t     exp_adr [0:31];            // Expected stores in order
    word_t     exp_dat [0:31];
    int        n_exp = 0;
    int        store_idx = 0;
    int        cycles = 0;
    int        pc_w = 0;                  // Word index while loading
    int        wait_cnt;
    word_t     auipc_pc, jal_pc, jalr_pc, jalr_tgt;
    logic      store_ack;

    tb_clkgen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    rv_core_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .iwb_req_o(iwb_req),
        .iwb_rsp_i(iwb_rsp),
        .dwb_req_o(dwb_req),
        .dwb_rsp_i(dwb_rsp),
        .halted_o (halted)
    );

    tb_wb_mem u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .iwb_req_i(iwb_req),
        .iwb_rsp_o(iwb_rsp),
        .dwb_req_i(dwb_req),
        .dwb_rsp_o(dwb_rsp)
    );

    assign store_ack = dwb_req.cyc && dwb_req.stb && dwb_req.we && dwb_rsp.ack;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (store_ack) begin
            store_idx <= store_idx + 1;   // Next table entry
        end
    end

    // ==================================================
    // Instruction encoders
    // ==================================================
    function automatic word_t r_type(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        r_type = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(input int imm, input int rs1, input int f3,
                                     input int rd, input int op);
        i_type = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t s_type(input int imm, input int rs2, input int rs1);
        s_type = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input int imm, input int rs2, input int rs1, input int f3);
        b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                  7'b1100011};
    endfunction

    function automatic word_t u_type(input int imm20, input int rd, input int op);
        u_type = {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t j_type(input int imm, input int rd);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input word_t w);
        u_mem.ram[pc_w] = w;
        pc_w++;
    endtask

    task automatic expect_store(input word_t adr, input word_t dat);
        exp_adr[n_exp] = adr;
        exp_dat[n_exp] = dat;
        n_exp++;
    endtask

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_value(input string name, input word_t expected, input word_t actual);
        $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        abort_run();
    endtask

    // ==================================================
    // Test program with x1 as the 0x1000 data base
    // ==================================================
    task automatic load_program();
        for (int i = 0; i < 2048; i++) begin
            u_mem.ram[i] = ~(i << 2);             // Address dependent fill
        end
        emit(u_type('h1, 1, opc_lui));
        emit(i_type(100, 0, 0, 2, opc_imm));      // x2 = 100
        emit(i_type(-7, 0, 0, 3, opc_imm));       // x3 = -7
        emit(r_type(0, 3, 2, 0, 4));              // add
        emit(s_type(0, 4, 1));
        emit(r_type('h20, 2, 3, 0, 5));           // sub x3 - x2
        emit(s_type(4, 5, 1));
        emit(i_type(4, 2, 1, 6, opc_imm));        // slli
        emit(s_type(8, 6, 1));
        emit(i_type('h401, 3, 5, 7, opc_imm));    // srai by 1
        emit(s_type(12, 7, 1));
        emit(i_type(28, 3, 5, 8, opc_imm));       // srli by 28
        emit(s_type(16, 8, 1));
        emit(r_type(0, 2, 3, 2, 9));              // slt
        emit(s_type(20, 9, 1));
        emit(r_type(0, 2, 3, 3, 10));             // sltu
        emit(s_type(24, 10, 1));
        emit(i_type('hff, 2, 4, 11, opc_imm));    // xori
        emit(s_type(28, 11, 1));
        emit(r_type(0, 3, 2, 6, 12));             // or
        emit(s_type(32, 12, 1));
        emit(i_type('hf0, 3, 7, 13, opc_imm));    // andi
        emit(s_type(36, 13, 1));
        emit(u_type('habcde, 14, opc_lui));
        emit(s_type(40, 14, 1));
        auipc_pc = pc_w * 4;
        emit(u_type('h2, 15, opc_auipc));
        emit(s_type(44, 15, 1));
        emit(i_type(5, 2, 0, 0, opc_imm));        // Write to x0
        emit(s_type(48, 0, 1));
        emit(r_type('h20, 9, 3, 5, 16));          // sra by x9
        emit(s_type(52, 16, 1));
        emit(i_type(-1, 2, 3, 17, opc_imm));      // sltiu
        emit(s_type(56, 17, 1));
        // Store, load back, increment, store again
        emit(s_type(60, 2, 1));
        emit(i_type(60, 1, 2, 18, opc_load));
        emit(i_type(1, 18, 0, 18, opc_imm));
        emit(s_type(64, 18, 1));
        // Branches on x3 = -7 and x2 = 100
        emit(b_type(8, 2, 3, 4));                 // blt taken
        emit(s_type(200, 3, 1));                  // Skipped
        emit(b_type(8, 2, 3, 5));                 // bge falls through
        emit(s_type(68, 2, 1));
        emit(b_type(8, 2, 3, 7));                 // bgeu taken
        emit(s_type(204, 3, 1));                  // Skipped
        emit(b_type(8, 2, 3, 6));                 // bltu falls through
        emit(s_type(72, 4, 1));
        jal_pc = pc_w * 4;
        emit(j_type(8, 19));
        emit(s_type(208, 3, 1));                  // Skipped
        emit(s_type(76, 19, 1));
        jalr_tgt = pc_w * 4 + 20;                 // Past addi, jalr and three stores
        emit(i_type(int'(jalr_tgt) + 1, 0, 0, 21, opc_imm));   // Bit 0 set on purpose
        jalr_pc = pc_w * 4;
        emit(i_type(0, 21, 0, 20, opc_jalr));
        emit(s_type(212, 3, 1));                  // Skipped
        emit(s_type(216, 3, 1));
        emit(s_type(220, 3, 1));
        emit(s_type(80, 20, 1));
        emit(32'h0000_000b);                      // custom-0 is unsupported
    endtask

    // Expected values from RV32I semantics
    task automatic build_table();
        expect_store(32'h1000, 32'h0000_005d);    // 100 + -7
        expect_store(32'h1004, 32'hffff_ff95);    // -7 - 100
        expect_store(32'h1008, 32'h0000_0640);
        expect_store(32'h100c, 32'hffff_fffc);    // Arithmetic shift keeps sign
        expect_store(32'h1010, 32'h0000_000f);
        expect_store(32'h1014, 32'h0000_0001);
        expect_store(32'h1018, 32'h0000_0000);    // Unsigned -7 is large
        expect_store(32'h101c, 32'h0000_009b);
        expect_store(32'h1020, 32'hffff_fffd);
        expect_store(32'h1024, 32'h0000_00f0);
        expect_store(32'h1028, 32'habcd_e000);
        expect_store(32'h102c, auipc_pc + 32'h2000);
        expect_store(32'h1030, 32'h0000_0000);    // x0 stays zero
        expect_store(32'h1034, 32'hffff_fffc);
        expect_store(32'h1038, 32'h0000_0001);
        expect_store(32'h103c, 32'h0000_0064);
        expect_store(32'h1040, 32'h0000_0065);    // Loaded word plus one
        expect_store(32'h1044, 32'h0000_0064);
        expect_store(32'h1048, 32'h0000_005d);
        expect_store(32'h104c, jal_pc + 4);       // Link values
        expect_store(32'h1050, jalr_pc + 4);
    endtask

    // ==================================================
    // Assertions
    // ==================================================
    a_reset_idle: assert property (@(posedge clk) (!rst_n && cycles > 0) |->
            (!iwb_req.cyc && !dwb_req.cyc && !halted && iwb_req.adr == reset_pc))
        else begin
            $display("Bus cycle, halt or fetch address not at reset values during reset");
            abort_run();
        end

    a_first_fetch: assert property (@(posedge clk) $rose(rst_n) |->
            (iwb_req.cyc && iwb_req.stb && iwb_req.adr == reset_pc))
        else report_value("first_fetch_adr", reset_pc, $sampled(iwb_req.adr));

    a_store_count: assert property (@(posedge clk) disable iff (!rst_n)
            store_ack |-> store_idx < n_exp)
        else begin
            $display("More stores on the data bus than the table expects");
            abort_run();
        end

    a_store_adr: assert property (@(posedge clk) disable iff (!rst_n)
            store_ack |-> dwb_req.adr == exp_adr[store_idx])
        else report_value("store_adr", exp_adr[$sampled(store_idx)], $sampled(dwb_req.adr));

    a_store_dat: assert property (@(posedge clk) disable iff (!rst_n)
            store_ack |-> dwb_req.dat == exp_dat[store_idx])
        else report_value("store_dat", exp_dat[$sampled(store_idx)], $sampled(dwb_req.dat));

    // Word access uses all four byte lanes
    a_dbus_sel: assert property (@(posedge clk) disable iff (!rst_n)
            dwb_req.cyc |-> dwb_req.sel == 4'b1111)
        else report_value("dbus_sel", 32'h0000_000f, {28'h0, $sampled(dwb_req.sel)});

    // Requests hold until ack
    a_ibus_hold: assert property (@(posedge clk) disable iff (!rst_n)
            $past(iwb_req.stb && !iwb_rsp.ack) |-> (iwb_req.stb && $stable(iwb_req.adr)))
        else begin
            $display("Instruction bus request changed before ack");
            abort_run();
        end

    a_dbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
            $past(dwb_req.stb && !dwb_rsp.ack) |-> (dwb_req.stb && $stable(dwb_req.adr)
            && $stable(dwb_req.dat) && $stable(dwb_req.we)))
        else begin
            $display("Data bus request changed before ack");
            abort_run();
        end

    a_bus_excl: assert property (@(posedge clk) disable iff (!rst_n)
            !(iwb_req.cyc && dwb_req.cyc))
        else begin
            $display("Both buses active in the same cycle");
            abort_run();
        end

    a_halt_done: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(halted) |-> store_idx == n_exp)
        else report_value("stores_at_halt", n_exp, $sampled(store_idx));

    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
            halted |-> (!iwb_req.cyc && !dwb_req.cyc))
        else begin
            $display("Bus cycle started after halt");
            abort_run();
        end

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
            $past(halted) |-> halted)
        else begin
            $display("Halt dropped without reset");
            abort_run();
        end

    // ==================================================
    // Run until halt
    // ==================================================
    initial begin
        load_program();
        build_table();
        wait_cnt = 0;
        while (!halted && wait_cnt < halt_timeout) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!halted) begin
            $display("Timeout: core did not halt within %0d cycles", halt_timeout);
            abort_run();
        end else begin
            repeat (8) @(posedge clk);            // Bus must stay idle
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- tb_wb_mem.sv
// ==================================================
// Wishbone memory model for both core buses
// 8 KB word array with random 0 to 3 cycle ack delay
// ==================================================
`timescale 1ns/10ps

module tb_wb_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_bus_pkg::ibus_req_t iwb_req_i,
    output rv_bus_pkg::bus_rsp_t  iwb_rsp_o,
    input  rv_bus_pkg::dbus_req_t dwb_req_i,
    output rv_bus_pkg::bus_rsp_t  dwb_rsp_o
);
    import rv_isa_pkg::*;

    word_t  ram [0:2047];            // Preloaded by the testbench top
    integer seed     = 32'he2d6cde8;
    logic   i_ack_q  = 1'b0;
    logic   d_ack_q  = 1'b0;
    word_t  rdata_q  = '0;
    logic   armed    = 1'b0;         // Delay already drawn for this request
    int     wait_cnt = 0;
    int     delay;
    logic   i_req, d_req;

    // New request rather than the one just acked
    assign i_req = iwb_req_i.cyc && iwb_req_i.stb && !i_ack_q;
    assign d_req = dwb_req_i.cyc && dwb_req_i.stb && !d_ack_q;

    assign iwb_rsp_o.dat = rdata_q;
    assign iwb_rsp_o.ack = i_ack_q;
    assign dwb_rsp_o.dat = rdata_q;
    assign dwb_rsp_o.ack = d_ack_q;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            i_ack_q  <= 1'b0;
            d_ack_q  <= 1'b0;
            armed    <= 1'b0;
            wait_cnt <= 0;
        end else begin
            i_ack_q <= 1'b0;                  // Single cycle ack
            d_ack_q <= 1'b0;
            if (i_req || d_req) begin
                delay = armed ? wait_cnt : ($random(seed) & 3);
                if (delay == 0) begin
                    armed <= 1'b0;
                    if (i_req) begin          // Fetch has priority
                        i_ack_q <= 1'b1;
                        rdata_q <= ram[iwb_req_i.adr[12:2]];
                    end else begin
                        d_ack_q <= 1'b1;
                        rdata_q <= ram[dwb_req_i.adr[12:2]];
                        if (dwb_req_i.we) begin
                            ram[dwb_req_i.adr[12:2]] = dwb_req_i.dat;
                        end
                    end
                end else begin
                    armed    <= 1'b1;         // Back-pressure keeps the master waiting
                    wait_cnt <= delay - 1;
                end
            end
        end
    end

endmodule

//--- tb_clkgen.sv
// ==================================================
// Testbench clock and reset source
// 100 ns clock, reset held low for 16 cycles
// ==================================================
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int half_period  = 50,   // ns
    parameter int reset_cycles = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;                 // Reset from time zero
        forever #(half_period) clk_o = ~clk_o;
    end

    // Release on a rising edge
    initial begin
        repeat (reset_cycles) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- rv_core_top.sv
// ==================================================
// RV32I multi-cycle core, two Wishbone masters
// ==================================================
`timescale 1ns/10ps

module rv_core_top #(
    parameter rv_isa_pkg::word_t reset_vector = rv_isa_pkg::reset_pc
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output rv_bus_pkg::ibus_req_t iwb_req_o,
    input  rv_bus_pkg::bus_rsp_t  iwb_rsp_i,
    output rv_bus_pkg::dbus_req_t dwb_req_o,
    input  rv_bus_pkg::bus_rsp_t  dwb_rsp_i,
    output logic                  halted_o
);
    import rv_isa_pkg::*;

    word_t          instr;
    decoded_instr_t dec;
    word_t          rs1_data, rs2_data;
    word_t          alu_a, alu_b, alu_result;
    logic           branch_taken;
    logic           rd_we;
    reg_idx_t       rd_idx;
    word_t          rd_data;

    core_ctrl #(
        .reset_vector(reset_vector)
    ) u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .iwb_req_o     (iwb_req_o),
        .iwb_rsp_i     (iwb_rsp_i),
        .dwb_req_o     (dwb_req_o),
        .dwb_rsp_i     (dwb_rsp_i),
        .instr_o       (instr),
        .dec_i         (dec),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .alu_a_o       (alu_a),
        .alu_b_o       (alu_b),
        .alu_result_i  (alu_result),
        .branch_taken_i(branch_taken),
        .rd_we_o       (rd_we),
        .rd_idx_o      (rd_idx),
        .rd_data_o     (rd_data),
        .halted_o      (halted_o)
    );

    instr_decoder u_dec (
        .instr_i(instr),
        .dec_o  (dec)
    );

    alu u_alu (
        .a_i           (alu_a),
        .b_i           (alu_b),
        .op_i          (dec.alu_op),
        .funct3_i      (dec.funct3),
        .result_o      (alu_result),
        .branch_taken_o(branch_taken)
    );

    regfile u_rf (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_idx_i (dec.rs1),
        .rs2_idx_i (dec.rs2),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .we_i      (rd_we),
        .rd_idx_i  (rd_idx),
        .rd_data_i (rd_data)
    );

endmodule

//--- core_ctrl.sv
// ==================================================
// Core control FSM with PC and both Wishbone masters
// Writeback select, next PC and halt on bad opcode
// ==================================================
`timescale 1ns/10ps

module core_ctrl #(
    parameter rv_isa_pkg::word_t reset_vector = rv_isa_pkg::reset_pc
) (
    input  logic                       clk,
    input  logic                       rst_n,
    output rv_bus_pkg::ibus_req_t      iwb_req_o,
    input  rv_bus_pkg::bus_rsp_t       iwb_rsp_i,
    output rv_bus_pkg::dbus_req_t      dwb_req_o,
    input  rv_bus_pkg::bus_rsp_t       dwb_rsp_i,
    output rv_isa_pkg::word_t          instr_o,
    input  rv_isa_pkg::decoded_instr_t dec_i,
    input  rv_isa_pkg::word_t          rs1_data_i,
    input  rv_isa_pkg::word_t          rs2_data_i,
    output rv_isa_pkg::word_t          alu_a_o,
    output rv_isa_pkg::word_t          alu_b_o,
    input  rv_isa_pkg::word_t          alu_result_i,
    input  logic                       branch_taken_i,
    output logic                       rd_we_o,
    output rv_isa_pkg::reg_idx_t       rd_idx_o,
    output rv_isa_pkg::word_t          rd_data_o,
    output logic                       halted_o
);
    import rv_isa_pkg::*;

    ctrl_state_t state_q;
    word_t       pc_q;
    word_t       instr_q;     // Instruction register
    word_t       alu_q;       // ALU result from execute
    word_t       load_q;      // LW data
    word_t       pc_plus4;
    word_t       pc_next;
    logic        writes_rd;
    logic        is_link;     // JAL / JALR

    assign instr_o  = instr_q;
    assign pc_plus4 = pc_q + 32'd4;
    assign is_link  = (dec_i.iclass == cls_jal) || (dec_i.iclass == cls_jalr);
    assign halted_o = (state_q == st_halt);

    // Operand muxes
    assign alu_a_o = (dec_i.iclass == cls_auipc) ? pc_q : rs1_data_i;
    assign alu_b_o = dec_i.uses_imm ? dec_i.imm : rs2_data_i;

    // ==================================================
    // Wishbone masters driven from state
    // ==================================================
    always_comb begin
        iwb_req_o     = '0;
        iwb_req_o.adr = pc_q;                  // PC held through fetch
        iwb_req_o.cyc = rst_n && (state_q == st_fetch);   // Idle while in reset
        iwb_req_o.stb = rst_n && (state_q == st_fetch);
    end

    always_comb begin
        dwb_req_o     = '0;
        dwb_req_o.adr = alu_q;                 // rs1 + imm
        dwb_req_o.dat = rs2_data_i;            // Regfile untouched during mem
        dwb_req_o.we  = (dec_i.iclass == cls_store);
        dwb_req_o.sel = 4'b1111;
        dwb_req_o.cyc = (state_q == st_mem);
        dwb_req_o.stb = (state_q == st_mem);
    end

    // ==================================================
    // Writeback and next PC
    // ==================================================
    always_comb begin
        case (dec_i.iclass)
            cls_op, cls_op_imm, cls_lui, cls_auipc,
            cls_jal, cls_jalr, cls_load: writes_rd = 1'b1;
            default:                     writes_rd = 1'b0;
        endcase
    end

    assign rd_we_o   = (state_q == st_writeback) && writes_rd;
    assign rd_idx_o  = dec_i.rd;
    assign rd_data_o = (dec_i.iclass == cls_load) ? load_q :
                       is_link                    ? pc_plus4 :   // Link address
                                                    alu_q;

    // Branch operands still valid as rs1/rs2 are unchanged since execute
    always_comb begin
        case (dec_i.iclass)
            cls_jal:    pc_next = pc_q + dec_i.imm;
            cls_jalr:   pc_next = {alu_q[31:1], 1'b0};
            cls_branch: pc_next = branch_taken_i ? pc_q + dec_i.imm : pc_plus4;
            default:    pc_next = pc_plus4;
        endcase
    end

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_fetch;
            pc_q    <= reset_vector;
        end else begin
            case (state_q)
                st_fetch: begin
                    if (iwb_rsp_i.ack) begin
                        state_q <= st_execute;
                    end
                end
                st_execute: begin
                    case (dec_i.iclass)
                        cls_load, cls_store: state_q <= st_mem;
                        cls_unsupported:     state_q <= st_halt;   // Sticky
                        default:             state_q <= st_writeback;
                    endcase
                end
                st_mem: begin
                    if (dwb_rsp_i.ack) begin
                        state_q <= st_writeback;
                    end
                end
                st_writeback: begin
                    pc_q    <= pc_next;
                    state_q <= st_fetch;
                end
                default: state_q <= st_halt;   // Wait for reset
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (state_q == st_fetch && iwb_rsp_i.ack) begin
            instr_q <= iwb_rsp_i.dat;
        end
        if (state_q == st_execute) begin
            alu_q <= alu_result_i;
        end
        if (state_q == st_mem && dwb_rsp_i.ack) begin
            load_q <= dwb_rsp_i.dat;
        end
    end

endmodule

//--- regfile.sv
// ==================================================
// Integer register file, x1 to x31
// Two async read ports, one write port, x0 is zero
// ==================================================
`timescale 1ns/10ps

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_isa_pkg::reg_idx_t rs1_idx_i,
    input  rv_isa_pkg::reg_idx_t rs2_idx_i,
    output rv_isa_pkg::word_t    rs1_data_o,
    output rv_isa_pkg::word_t    rs2_data_o,
    input  logic                 we_i,
    input  rv_isa_pkg::reg_idx_t rd_idx_i,
    input  rv_isa_pkg::word_t    rd_data_i
);
    import rv_isa_pkg::*;

    word_t regs [1:31];   // No storage behind x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_idx_i != '0) begin   // x0 writes dropped
            regs[rd_idx_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

//--- alu.sv
// ==================================================
// Integer ALU with branch condition compare
// ==================================================
`timescale 1ns/10ps

module alu (
    input  rv_isa_pkg::word_t   a_i,
    input  rv_isa_pkg::word_t   b_i,
    input  rv_isa_pkg::alu_op_t op_i,
    input  logic [2:0]          funct3_i,
    output rv_isa_pkg::word_t   result_o,
    output logic                branch_taken_o
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];   // Low five bits only

    always_comb begin
        case (op_i)
            alu_add:    result_o = a_i + b_i;
            alu_sub:    result_o = a_i - b_i;
            alu_sll:    result_o = a_i << shamt;
            alu_slt:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            alu_sltu:   result_o = {31'b0, a_i < b_i};
            alu_xor:    result_o = a_i ^ b_i;
            alu_srl:    result_o = a_i >> shamt;
            alu_sra:    result_o = $signed(a_i) >>> shamt;
            alu_or:     result_o = a_i | b_i;
            alu_and:    result_o = a_i & b_i;
            alu_pass_b: result_o = b_i;            // LUI
            default:    result_o = a_i + b_i;
        endcase
    end

    // Branch compare straight off the operands
    always_comb begin
        case (funct3_i)
            f3_beq:  branch_taken_o = (a_i == b_i);
            f3_bne:  branch_taken_o = (a_i != b_i);
            f3_blt:  branch_taken_o = ($signed(a_i) < $signed(b_i));
            f3_bge:  branch_taken_o = ($signed(a_i) >= $signed(b_i));
            f3_bltu: branch_taken_o = (a_i < b_i);
            f3_bgeu: branch_taken_o = (a_i >= b_i);
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

//--- instr_decoder.sv
// ==================================================
// RV32I instruction decoder
// Fields, immediates, ALU op and instruction class
// ==================================================
`timescale 1ns/10ps

module instr_decoder (
    input  rv_isa_pkg::word_t          instr_i,
    output rv_isa_pkg::decoded_instr_t dec_o
);
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] f3;
    logic       f7_zero;
    logic       f7_alt;   // SUB / SRA encoding
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic alu_op_t map_alu(input logic [2:0] code, input logic alt);
        case (code)
            f3_add_sub: map_alu = alt ? alu_sub : alu_add;
            f3_sll:     map_alu = alu_sll;
            f3_slt:     map_alu = alu_slt;
            f3_sltu:    map_alu = alu_sltu;
            f3_xor:     map_alu = alu_xor;
            f3_srl_sra: map_alu = alt ? alu_sra : alu_srl;
            f3_or:      map_alu = alu_or;
            default:    map_alu = alu_and;
        endcase
    endfunction

    assign opcode  = instr_i[6:0];
    assign f3      = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // ==================================================
    // Immediate formats
    // ==================================================
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        dec_o          = '0;
        dec_o.iclass   = cls_unsupported;   // Until proven otherwise
        dec_o.alu_op   = alu_add;
        dec_o.funct3   = f3;
        dec_o.rd       = instr_i[11:7];
        dec_o.rs1      = instr_i[19:15];
        dec_o.rs2      = instr_i[24:20];
        dec_o.imm      = imm_i;
        dec_o.uses_imm = 1'b1;

        case (opcode)
            op_lui: begin
                dec_o.iclass = cls_lui;
                dec_o.alu_op = alu_pass_b;
                dec_o.imm    = imm_u;
            end
            op_auipc: begin
                dec_o.iclass = cls_auipc;   // PC + imm, A muxed in ctrl
                dec_o.imm    = imm_u;
            end
            op_jal: begin
                dec_o.iclass = cls_jal;
                dec_o.imm    = imm_j;
            end
            op_jalr: begin
                dec_o.iclass = cls_jalr;    // Target rs1 + imm from ALU
            end
            op_branch: begin
                if (f3[2:1] != 2'b01) begin
                    dec_o.iclass = cls_branch;
                end
                dec_o.imm      = imm_b;
                dec_o.uses_imm = 1'b0;      // Compare rs1 with rs2
            end
            op_load: begin
                if (f3 == f3_word) begin
                    dec_o.iclass = cls_load;
                end
            end
            op_store: begin
                if (f3 == f3_word) begin
                    dec_o.iclass = cls_store;
                end
                dec_o.imm = imm_s;
            end
            op_op_imm: begin
                // Only shifts carry a funct7 field
                if ((f3 != f3_sll && f3 != f3_srl_sra) ||
                    f7_zero || (f3 == f3_srl_sra && f7_alt)) begin
                    dec_o.iclass = cls_op_imm;
                end
                dec_o.alu_op = map_alu(f3, f3 == f3_srl_sra && f7_alt);
            end
            op_op: begin
                if (f7_zero || (f7_alt && (f3 == f3_add_sub || f3 == f3_srl_sra))) begin
                    dec_o.iclass = cls_op;
                end
                dec_o.alu_op   = map_alu(f3, f7_alt);
                dec_o.uses_imm = 1'b0;
            end
            default: begin
                dec_o.iclass = cls_unsupported;
            end
        endcase
    end

endmodule

//--- rv_bus_pkg.sv
// ==================================================
// Wishbone B4 classic request and response bundles
// ==================================================
package rv_bus_pkg;

    // Instruction bus, read only
    typedef struct packed {
        rv_isa_pkg::word_t adr;
        logic              cyc;
        logic              stb;
    } ibus_req_t;

    // Data bus
    typedef struct packed {
        rv_isa_pkg::word_t adr;
        rv_isa_pkg::word_t dat;
        logic              we;
        logic [3:0]        sel;   // Always all lanes, word access only
        logic              cyc;
        logic              stb;
    } dbus_req_t;

    // Slave response, shared by both buses
    typedef struct packed {
        rv_isa_pkg::word_t dat;
        logic              ack;
    } bus_rsp_t;

endpackage

//--- rv_isa_pkg.sv
// ==================================================
// RV32I ISA definitions shared by the core blocks
// Opcodes, funct3 codes, ALU ops and decoded fields
// ==================================================
package rv_isa_pkg;

    typedef logic [31:0] word_t;     // Data, address or instruction word
    typedef logic [4:0]  reg_idx_t;  // Register index

    // ==================================================
    // Major opcodes
    // ==================================================
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // ALU groups, plus the word width for LW/SW
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;

    localparam word_t reset_pc = 32'h0000_0000;  // Default reset vector

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef enum logic [3:0] {
        cls_op, cls_op_imm, cls_lui, cls_auipc, cls_branch,
        cls_jal, cls_jalr, cls_load, cls_store, cls_unsupported
    } instr_class_t;

    typedef struct packed {
        instr_class_t iclass;
        alu_op_t      alu_op;
        logic [2:0]   funct3;
        reg_idx_t     rd;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        word_t        imm;
        logic         uses_imm;  // Immediate as ALU operand B
    } decoded_instr_t;

    typedef enum logic [2:0] {
        st_fetch, st_execute, st_mem, st_writeback, st_halt
    } ctrl_state_t;

endpackage
